// ==== src/dvi_pkg.sv ====
// Video mode timing, pixel and symbol types, control register map
// and raster region encoding for the 640x480p DVI transmitter

`default_nettype none

package dvi_pkg;

// ----------------------------------------
// 640x480p 60 Hz raster, CEA-861

localparam int H_ACTIVE = 640;
localparam int H_FRONT  = 16;
localparam int H_SYNC   = 96;
localparam int H_BACK   = 48;
localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK; // 800 pixels

localparam int V_ACTIVE = 480;
localparam int V_FRONT  = 10;
localparam int V_SYNC   = 2;
localparam int V_BACK   = 33;
localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK; // 525 lines

localparam logic SYNC_ACTIVE_LEVEL = 1'b0; // Both syncs active low

// ----------------------------------------
// Types

typedef logic [10:0] coord_t;    // Pixel, line or frame count
typedef logic [7:0]  colour_t;
typedef logic [9:0]  tmds_sym_t;
typedef logic [1:0]  cfg_addr_t;
typedef logic [7:0]  cfg_data_t;

// ----------------------------------------
// Register map

localparam cfg_addr_t REG_CTRL = 2'd0;
localparam int CTRL_ENABLE_BIT = 0;
localparam int CTRL_FREEZE_BIT = 1; // Holds the frame counter

// Horizontal raster regions, in line order
typedef enum logic [1:0] {
	ACTIVE,
	FRONT,
	SYNC,
	BACK
} timing_region_t;

endpackage

`default_nettype wire

// ==== src/dvi_cfg_regs.sv ====
// Control register block with a one-entry pending write
// Writes land at the next frame start, or at once while disabled

`timescale 1ns/1ns
`default_nettype none

module dvi_cfg_regs import dvi_pkg::*; (
	input  wire             clk_dvi_pix,
	input  wire             rst_n_dvi_pix,

	input  wire             i_cfg_valid,
	input  wire cfg_addr_t  i_cfg_addr,
	input  wire cfg_data_t  i_cfg_wdata,
	output logic            o_cfg_ready,

	input  wire             i_frame_start,
	output logic            o_enable,
	output logic            o_freeze
);

logic pend_valid;
logic pend_enable;
logic pend_freeze;
logic cfg_xfer;
logic apply;

// Only one write in flight
assign o_cfg_ready = !pend_valid;
assign cfg_xfer    = i_cfg_valid && o_cfg_ready;

// Frame boundary, or nothing on screen to disturb
assign apply = pend_valid && (i_frame_start || !o_enable);

// ----------------------------------------
// Control state

always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
	if (!rst_n_dvi_pix) begin
		pend_valid <= 1'b0;
		o_enable   <= 1'b0;
		o_freeze   <= 1'b0;
	end else if (apply) begin
		pend_valid <= 1'b0;
		o_enable   <= pend_enable;
		o_freeze   <= pend_freeze;
	end else if (cfg_xfer && i_cfg_addr == REG_CTRL) begin
		pend_valid <= 1'b1; // Other addresses are taken and dropped
	end
end

// Pending value, qualified by pend_valid
always_ff @(posedge clk_dvi_pix) begin
	if (cfg_xfer) begin
		pend_enable <= i_cfg_wdata[CTRL_ENABLE_BIT];
		pend_freeze <= i_cfg_wdata[CTRL_FREEZE_BIT];
	end
end

endmodule

`default_nettype wire

// ==== src/dvi_timing.sv ====
// Raster timing generator for the 800x525 frame
// Produces syncs, data enable, pixel ready and the frame start pulse

`timescale 1ns/1ns
`default_nettype none

module dvi_timing import dvi_pkg::*; (
	input  wire   clk_dvi_pix,
	input  wire   rst_n_dvi_pix,

	input  wire   i_enable,

	output logic  o_hsync,
	output logic  o_vsync,
	output logic  o_de,
	output logic  o_frame_start,
	output logic  o_pix_ready
);

// Last pixel of each horizontal region
localparam coord_t H_ACTIVE_LAST = coord_t'(H_ACTIVE - 1);
localparam coord_t H_FRONT_LAST  = coord_t'(H_ACTIVE + H_FRONT - 1);
localparam coord_t H_SYNC_LAST   = coord_t'(H_ACTIVE + H_FRONT + H_SYNC - 1);
localparam coord_t H_LAST        = coord_t'(H_TOTAL - 1);

// Vertical sync window, lines 490 and 491
localparam coord_t V_SYNC_FIRST  = coord_t'(V_ACTIVE + V_FRONT);
localparam coord_t V_SYNC_LAST   = coord_t'(V_ACTIVE + V_FRONT + V_SYNC - 1);
localparam coord_t V_LAST        = coord_t'(V_TOTAL - 1);

coord_t         h_ctr;
coord_t         v_ctr;
timing_region_t h_region;
logic           v_active;
logic           v_in_sync;

// ----------------------------------------
// Position counters

always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
	if (!rst_n_dvi_pix) begin
		h_ctr    <= '0;
		v_ctr    <= '0;
		h_region <= ACTIVE;
	end else if (!i_enable) begin
		h_ctr    <= '0; // Parked at the origin
		v_ctr    <= '0;
		h_region <= ACTIVE;
	end else begin
		h_ctr <= h_ctr + coord_t'(1);
		case (h_ctr)
			H_ACTIVE_LAST: h_region <= FRONT;
			H_FRONT_LAST:  h_region <= SYNC;
			H_SYNC_LAST:   h_region <= BACK;
			default:       h_region <= h_region;
		endcase
		if (h_ctr == H_LAST) begin
			h_ctr    <= '0;
			h_region <= ACTIVE;
			if (v_ctr == V_LAST)
				v_ctr <= '0;
			else
				v_ctr <= v_ctr + coord_t'(1);
		end
	end
end

// ----------------------------------------
// Outputs, decoded from the position

assign v_active  = v_ctr < coord_t'(V_ACTIVE);
assign v_in_sync = v_ctr >= V_SYNC_FIRST && v_ctr <= V_SYNC_LAST;

assign o_hsync = (h_region == SYNC) ? SYNC_ACTIVE_LEVEL : !SYNC_ACTIVE_LEVEL;
assign o_vsync = v_in_sync ? SYNC_ACTIVE_LEVEL : !SYNC_ACTIVE_LEVEL;

// Enable gate keeps the parked origin out of active video
assign o_de          = i_enable && h_region == ACTIVE && v_active;
assign o_frame_start = i_enable && h_ctr == '0 && v_ctr == '0;
assign o_pix_ready   = o_de; // Never stalls inside active video

endmodule

`default_nettype wire

// ==== src/test_pattern_gen.sv ====
// Moving colour test pattern source
// Pixel, line and frame counters advance on accepted pixels

`timescale 1ns/1ns
`default_nettype none

module test_pattern_gen import dvi_pkg::*; (
	input  wire      clk_dvi_pix,
	input  wire      rst_n_dvi_pix,

	input  wire      i_enable,
	input  wire      i_freeze,

	input  wire      i_pix_ready,
	output logic     o_pix_valid,
	output colour_t  o_red,
	output colour_t  o_green,
	output colour_t  o_blue
);

coord_t  pix_ctr;
coord_t  line_ctr;
coord_t  frame_ctr;
colour_t red_sum;
colour_t green_sum;
logic    pix_xfer;

assign o_pix_valid = i_enable;
assign pix_xfer    = o_pix_valid && i_pix_ready;

always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
	if (!rst_n_dvi_pix) begin
		pix_ctr   <= '0;
		line_ctr  <= '0;
		frame_ctr <= '0;
	end else if (!i_enable) begin
		pix_ctr  <= '0; // Realign with the parked raster
		line_ctr <= '0;
	end else if (pix_xfer) begin
		if (pix_ctr == coord_t'(H_ACTIVE - 1)) begin
			pix_ctr <= '0;
			if (line_ctr == coord_t'(V_ACTIVE - 1)) begin
				line_ctr <= '0;
				if (!i_freeze)
					frame_ctr <= frame_ctr + coord_t'(1);
			end else begin
				line_ctr <= line_ctr + coord_t'(1);
			end
		end else begin
			pix_ctr <= pix_ctr + coord_t'(1);
		end
	end
end

// Diagonal ramps drifting with the frame count
assign red_sum   = pix_ctr[7:0] + frame_ctr[7:0];
assign green_sum = line_ctr[7:0] + frame_ctr[7:0];

assign o_red   = {red_sum[5:0], 2'b00};
assign o_green = {green_sum[5:0], 2'b00};
assign o_blue  = frame_ctr[7:0];

endmodule

`default_nettype wire

// ==== src/tmds_encoder.sv ====
// Single TMDS channel encoder
// Transition minimising stage, DC balancing stage and control symbols

`timescale 1ns/1ns
`default_nettype none

module tmds_encoder import dvi_pkg::*; (
	input  wire           clk_dvi_pix,
	input  wire           rst_n_dvi_pix,

	input  wire           i_de,
	input  wire colour_t  i_data,
	input  wire           i_c0,
	input  wire           i_c1,

	output tmds_sym_t     o_sym
);

logic [3:0]        n1_data;
logic              use_xnor;
logic [8:0]        q_m;
logic [3:0]        n1_qm;
logic signed [5:0] diff_qm;  // Ones minus zeros of q_m[7:0]
logic signed [5:0] disp;     // Running disparity
logic signed [5:0] disp_next;
tmds_sym_t         data_sym;
tmds_sym_t         ctrl_sym;

// ----------------------------------------
// Stage 1, transition minimising

always_comb begin
	n1_data  = 4'($countones(i_data));
	use_xnor = n1_data > 4'd4 || (n1_data == 4'd4 && !i_data[0]);
	q_m[0]   = i_data[0];
	for (int i = 1; i < 8; i++)
		q_m[i] = use_xnor ? !(q_m[i-1] ^ i_data[i]) : (q_m[i-1] ^ i_data[i]);
	q_m[8] = !use_xnor;
	n1_qm   = 4'($countones(q_m[7:0]));
	diff_qm = $signed({1'b0, n1_qm, 1'b0}) - 6'sd8; // 2*n1 - 8
end

// ----------------------------------------
// Stage 2, DC balance

always_comb begin
	if (disp == 6'sd0 || diff_qm == 6'sd0) begin
		data_sym  = {!q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
		disp_next = q_m[8] ? disp + diff_qm : disp - diff_qm;
	end else if ((disp > 6'sd0 && diff_qm > 6'sd0) ||
		(disp < 6'sd0 && diff_qm < 6'sd0)) begin
		data_sym  = {1'b1, q_m[8], ~q_m[7:0]}; // Invert to pull back
		disp_next = disp + (q_m[8] ? 6'sd2 : 6'sd0) - diff_qm;
	end else begin
		data_sym  = {1'b0, q_m[8], q_m[7:0]};
		disp_next = disp - (q_m[8] ? 6'sd0 : 6'sd2) + diff_qm;
	end
end

// Control period symbols, selected by {c1, c0}
always_comb begin
	case ({i_c1, i_c0})
		2'b00:   ctrl_sym = 10'b1101010100;
		2'b01:   ctrl_sym = 10'b0010101011;
		2'b10:   ctrl_sym = 10'b0101010100;
		default: ctrl_sym = 10'b1010101011;
	endcase
end

always_ff @(posedge clk_dvi_pix or negedge rst_n_dvi_pix) begin
	if (!rst_n_dvi_pix)
		disp <= '0;
	else if (i_de)
		disp <= disp_next;
	else
		disp <= '0; // Balance restarts every blanking period
end

always_ff @(posedge clk_dvi_pix) begin
	o_sym <= i_de ? data_sym : ctrl_sym;
end

endmodule

`default_nettype wire

// ==== src/dvi_tx_core.sv ====
// DVI transmitter core on the pixel clock
// Control registers, raster timing, test pattern and three TMDS encoders

`timescale 1ns/1ns
`default_nettype none

module dvi_tx_core import dvi_pkg::*; (
	input  wire             clk_dvi_pix,
	input  wire             rst_n_dvi_pix,

	// Control write port
	input  wire             i_cfg_valid,
	input  wire cfg_addr_t  i_cfg_addr,
	input  wire cfg_data_t  i_cfg_wdata,
	output logic            o_cfg_ready,

	// Parallel TMDS symbols, one per pixel clock
	output tmds_sym_t       o_tmds0,
	output tmds_sym_t       o_tmds1,
	output tmds_sym_t       o_tmds2
);

logic    enable;
logic    freeze;
logic    frame_start;
logic    hsync;
logic    vsync;
logic    de;
logic    pix_ready;
logic    pix_valid;
colour_t red;
colour_t green;
colour_t blue;

// ----------------------------------------
// Control and timing

dvi_cfg_regs u_cfg_regs (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_cfg_valid   (i_cfg_valid),
	.i_cfg_addr    (i_cfg_addr),
	.i_cfg_wdata   (i_cfg_wdata),
	.o_cfg_ready   (o_cfg_ready),
	.i_frame_start (frame_start),
	.o_enable      (enable),
	.o_freeze      (freeze)
);

dvi_timing u_timing (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_enable      (enable),
	.o_hsync       (hsync),
	.o_vsync       (vsync),
	.o_de          (de),
	.o_frame_start (frame_start),
	.o_pix_ready   (pix_ready)
);

// ----------------------------------------
// Pixel source

test_pattern_gen u_pattern (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_enable      (enable),
	.i_freeze      (freeze),
	.i_pix_ready   (pix_ready),
	.o_pix_valid   (pix_valid),
	.o_red         (red),
	.o_green       (green),
	.o_blue        (blue)
);

// ----------------------------------------
// Encoders

tmds_encoder u_enc0 ( // Blue, carries the syncs
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_de          (de && pix_valid),
	.i_data        (blue),
	.i_c0          (hsync),
	.i_c1          (vsync),
	.o_sym         (o_tmds0)
);

tmds_encoder u_enc1 ( // Green
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_de          (de && pix_valid),
	.i_data        (green),
	.i_c0          (1'b0),
	.i_c1          (1'b0),
	.o_sym         (o_tmds1)
);

tmds_encoder u_enc2 ( // Red
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_de          (de && pix_valid),
	.i_data        (red),
	.i_c0          (1'b0),
	.i_c1          (1'b0),
	.o_sym         (o_tmds2)
);

endmodule

`default_nettype wire

// ==== tests/tb_tmds_decode.svh ====
// TMDS symbol decoding for the testbench
// Control code lookup, data byte recovery and symbol disparity

`ifndef TB_TMDS_DECODE_SVH
`define TB_TMDS_DECODE_SVH

// {c1, c0} of a control symbol, or -1 for any data symbol
function automatic int ctrl_code(input logic [9:0] sym);
	case (sym)
		10'b1101010100: return 0;
		10'b0010101011: return 1;
		10'b0101010100: return 2;
		10'b1010101011: return 3;
		default:        return -1;
	endcase
endfunction

// DVI data decode
function automatic logic [7:0] decode_data(input logic [9:0] sym);
	logic [7:0] q;
	logic [7:0] d;
	q = sym[9] ? ~sym[7:0] : sym[7:0]; // Undo the DC balance inversion
	d[0] = q[0];
	for (int i = 1; i < 8; i++) begin
		if (sym[8])
			d[i] = q[i] ^ q[i-1];
		else
			d[i] = ~(q[i] ^ q[i-1]); // XNOR coded
	end
	return d;
endfunction

// Ones minus zeros over all ten bits
function automatic int sym_disparity(input logic [9:0] sym);
	int ones;
	ones = 0;
	for (int i = 0; i < 10; i++)
		ones += sym[i];
	return 2 * ones - 10;
endfunction

`endif

// ==== tests/tb_dvi_tx.sv ====
// Directed testbench for the DVI transmitter core
// Reset state, raster timing, pattern content, freeze, control back-pressure

`timescale 1ns/1ns
`default_nettype none

module tb_dvi_tx import dvi_pkg::*; ();

`include "tb_tmds_decode.svh"

localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

logic      clk_dvi_pix;
logic      rst_n_dvi_pix;
logic      cfg_valid;
cfg_addr_t cfg_addr;
cfg_data_t cfg_wdata;
logic      cfg_ready;
tmds_sym_t tmds0;
tmds_sym_t tmds1;
tmds_sym_t tmds2;
int        n_checks;
int        n_errors;

dvi_tx_core dut (
	.clk_dvi_pix   (clk_dvi_pix),
	.rst_n_dvi_pix (rst_n_dvi_pix),
	.i_cfg_valid   (cfg_valid),
	.i_cfg_addr    (cfg_addr),
	.i_cfg_wdata   (cfg_wdata),
	.o_cfg_ready   (cfg_ready),
	.o_tmds0       (tmds0),
	.o_tmds1       (tmds1),
	.o_tmds2       (tmds2)
);

initial begin
	clk_dvi_pix = 1'b0;
	forever #4 clk_dvi_pix = ~clk_dvi_pix;
end

// ----------------------------------------
// Helpers

task automatic next_cycle();
	@(posedge clk_dvi_pix);
	#1; // Drive and sample just after the edge
endtask

task automatic apply_reset();
	rst_n_dvi_pix = 1'b0;
	cfg_valid     = 1'b0;
	repeat (10) next_cycle();
	rst_n_dvi_pix = 1'b1;
	next_cycle();
endtask

task automatic compare_value(input string test, input string what, input int exp, input int act);
	n_checks++;
	assert (exp == act) else begin
		n_errors++;
		$display("ERR %s %s: expected %0d, actual %0d", test, what, exp, act);
	end
endtask

task automatic expect_true(input string test, input bit ok, input string msg);
	n_checks++;
	assert (ok) else begin
		n_errors++;
		$display("%s: %s", test, msg);
	end
endtask

// Channel 0 control symbol with c1 low
function automatic bit is_vsync(input tmds_sym_t sym);
	return ctrl_code(sym) == 0 || ctrl_code(sym) == 1;
endfunction

function automatic bit within_balance(input int d);
	return d >= -10 && d <= 10;
endfunction

// Expected byte per channel, 0 blue, 1 green, 2 red
function automatic int pattern_byte(input int ch, input int x, input int line, input int frame_no);
	if (ch == 0)
		return frame_no % 256;
	else if (ch == 1)
		return ((line + frame_no) % 64) * 4;
	return ((x + frame_no) % 64) * 4;
endfunction

task automatic cfg_write(input string test, input cfg_addr_t addr, input cfg_data_t data);
	int n;
	n = 0;
	cfg_valid = 1'b1;
	cfg_addr  = addr;
	cfg_wdata = data;
	while (!cfg_ready && n < WAIT_LIMIT) begin
		next_cycle();
		n++;
	end
	expect_true(test, n < WAIT_LIMIT, "control write timed out waiting for ready");
	next_cycle(); // Transfer edge
	cfg_valid = 1'b0;
endtask

task automatic wait_data_start(input string test, input int limit);
	int n;
	n = 0;
	while (ctrl_code(tmds0) >= 0 && n < limit) begin
		next_cycle();
		n++;
	end
	expect_true(test, n < limit, "timed out waiting for a data symbol on channel 0");
endtask

task automatic wait_frame_start(input string test);
	int n;
	n = 0;
	while (!is_vsync(tmds0) && n < WAIT_LIMIT) begin
		next_cycle();
		n++;
	end
	expect_true(test, n < WAIT_LIMIT, "timed out waiting for vertical sync");
	wait_data_start(test, (V_SYNC + V_BACK + 1) * H_TOTAL);
endtask

// Line 0 content and running disparity, starting at its first symbol
task automatic verify_line(input string test, input int frame_no);
	int        disp [3];
	tmds_sym_t sym [3];
	disp = '{0, 0, 0};
	for (int x = 0; x < H_ACTIVE; x++) begin
		sym = '{tmds0, tmds1, tmds2};
		expect_true(test, ctrl_code(tmds0) < 0, "control symbol inside line 0");
		for (int ch = 0; ch < 3; ch++) begin
			compare_value(test, $sformatf("channel %0d pixel %0d", ch, x),
				pattern_byte(ch, x, 0, frame_no), decode_data(sym[ch]));
			disp[ch] += sym_disparity(sym[ch]);
			expect_true(test, within_balance(disp[ch]), "line 0 disparity out of range");
		end
		next_cycle();
	end
endtask

// Disparity of every remaining active line up to vertical sync
task automatic verify_balance_to_vsync(input string test);
	int        disp [3];
	tmds_sym_t sym [3];
	int        n;
	disp = '{0, 0, 0};
	n = 0;
	while (!is_vsync(tmds0) && n < FRAME_CYCLES) begin
		sym = '{tmds0, tmds1, tmds2};
		for (int ch = 0; ch < 3; ch++) begin
			if (ctrl_code(sym[ch]) < 0) begin
				disp[ch] += sym_disparity(sym[ch]);
				expect_true(test, within_balance(disp[ch]), "line disparity out of range");
			end else begin
				disp[ch] = 0; // New line
			end
		end
		next_cycle();
		n++;
	end
	expect_true(test, n < FRAME_CYCLES, "timed out waiting for vertical sync");
endtask

// ----------------------------------------
// Directed tests

task automatic reset_state_test();
	apply_reset();
	compare_value("reset_state", "ready", 1, cfg_ready);
	repeat (1000) begin
		compare_value("reset_state", "channel 0 code", 3, ctrl_code(tmds0));
		compare_value("reset_state", "channel 1 code", 0, ctrl_code(tmds1));
		compare_value("reset_state", "channel 2 code", 0, ctrl_code(tmds2));
		next_cycle();
	end
	cfg_write("reset_state", 2'd1, 8'h01); // Unmapped address is dropped
	repeat (100) begin
		compare_value("reset_state", "ready after unmapped write", 1, cfg_ready);
		compare_value("reset_state", "channel 0 code", 3, ctrl_code(tmds0));
		next_cycle();
	end
endtask

task automatic raster_timing_test();
	int code;
	int hs_len;
	int hs_runs;
	int last_hs;
	int de_len;
	int de_runs;
	int vs_cnt;
	hs_len  = 0;
	hs_runs = 0;
	last_hs = -1;
	de_len  = 0;
	de_runs = 0;
	vs_cnt  = 0;
	apply_reset();
	cfg_write("raster_timing", REG_CTRL, 8'h01);
	wait_data_start("raster_timing", 100);
	for (int i = 0; i < FRAME_CYCLES; i++) begin
		code = ctrl_code(tmds0);
		if (code == 0 || code == 1)
			vs_cnt++;
		if (code == 0 || code == 2) begin // c0 low
			if (hs_len == 0) begin
				if (last_hs >= 0)
					compare_value("raster_timing", "hsync period", H_TOTAL, i - last_hs);
				last_hs = i;
				hs_runs++;
			end
			hs_len++;
		end else if (hs_len > 0) begin
			compare_value("raster_timing", "hsync width", H_SYNC, hs_len);
			hs_len = 0;
		end
		if (code < 0) begin
			de_len++;
		end else if (de_len > 0) begin
			compare_value("raster_timing", "data run", H_ACTIVE, de_len);
			de_len = 0;
			de_runs++;
		end
		next_cycle();
	end
	compare_value("raster_timing", "hsync runs", V_TOTAL, hs_runs);
	compare_value("raster_timing", "data runs", V_ACTIVE, de_runs);
	compare_value("raster_timing", "vsync cycles", V_SYNC * H_TOTAL, vs_cnt);
endtask

task automatic pixel_content_test();
	apply_reset();
	cfg_write("pixel_content", REG_CTRL, 8'h01);
	wait_data_start("pixel_content", 100);
	verify_line("pixel_content", 0);
	verify_balance_to_vsync("pixel_content");
	wait_frame_start("pixel_content");
	verify_line("pixel_content", 1);
endtask

task automatic freeze_test();
	apply_reset();
	cfg_write("freeze", REG_CTRL, 8'h01);
	wait_data_start("freeze", 100);
	verify_line("freeze", 0);
	cfg_write("freeze", REG_CTRL, 8'h03); // Lands at the next frame start
	wait_frame_start("freeze");
	verify_line("freeze", 1);
	wait_frame_start("freeze");
	verify_line("freeze", 1);
endtask

task automatic back_pressure_test();
	int n;
	bit seen_vsync;
	n = 0;
	seen_vsync = 1'b0;
	apply_reset();
	cfg_write("back_pressure", REG_CTRL, 8'h01);
	wait_data_start("back_pressure", 100);
	cfg_write("back_pressure", REG_CTRL, 8'h00);
	compare_value("back_pressure", "ready after write", 0, cfg_ready);
	cfg_valid = 1'b1; // Second write, must not be taken
	cfg_wdata = 8'h01;
	repeat (100) begin
		compare_value("back_pressure", "ready while pending", 0, cfg_ready);
		next_cycle();
	end
	cfg_valid = 1'b0;
	while (!cfg_ready && n < WAIT_LIMIT) begin
		if (is_vsync(tmds0))
			seen_vsync = 1'b1;
		next_cycle();
		n++;
	end
	expect_true("back_pressure", n < WAIT_LIMIT, "ready never returned");
	expect_true("back_pressure", seen_vsync, "ready returned before the frame ended");
	expect_true("back_pressure", ctrl_code(tmds0) < 0, "ready did not follow the frame start");
	next_cycle();
	repeat (10 * H_TOTAL) begin
		compare_value("back_pressure", "channel 0 code after disable", 3, ctrl_code(tmds0));
		next_cycle();
	end
endtask

// ----------------------------------------
// Sequence

initial begin
	rst_n_dvi_pix = 1'b0;
	cfg_valid     = 1'b0;
	cfg_addr      = '0;
	cfg_wdata     = '0;
	n_checks      = 0;
	n_errors      = 0;
	reset_state_test();
	raster_timing_test();
	pixel_content_test();
	freeze_test();
	back_pressure_test();
	$display("Checks: %0d, errors: %0d", n_checks, n_errors);
	if (n_errors == 0)
		$display("Simulation completed successfully");
	else
		$display("Simulation failed");
	$finish;
end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+tests
src/dvi_pkg.sv
src/dvi_cfg_regs.sv
src/dvi_timing.sv
src/test_pattern_gen.sv
src/tmds_encoder.sv
src/dvi_tx_core.sv
tests/tb_dvi_tx.sv

// ==== Bender.yml ====
package:
  name: dvi_tx

sources:
  - src/dvi_pkg.sv
  - src/dvi_cfg_regs.sv
  - src/dvi_timing.sv
  - src/test_pattern_gen.sv
  - src/tmds_encoder.sv
  - src/dvi_tx_core.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_dvi_tx.sv
